// ==== project.f ====
logic/vec_pkg.sv
logic/reg_file_nr_1w.sv
logic/vec_issue.sv
logic/vec_lane.sv
logic/vec_collect.sv
logic/vec_unit_top.sv
sim/vec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the vector unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module vec_unit_tb \
  -f project.f \
  -o vec_unit_sim

output="$(./obj_dir/vec_unit_sim)"
echo "$output"

# Pass only when the testbench reports success
if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== sim/vec_unit_tb.sv ====
/*
  Vector unit testbench
  Directed tests against a per-lane register model, with a monitor
  that checks every result pulse against the queue of expected results
*/

`timescale 1ns/1ns

module vec_unit_tb
  import vec_pkg::*;
;

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                            clk_i = 1'b0;
  logic                            rst_n_i;
  logic                            instr_valid_i;
  opcode_e                         opcode_i;
  logic [index_width-1:0]          rd_i;
  logic [index_width-1:0]          rs1_i;
  logic [index_width-1:0]          rs2_i;
  logic [num_lanes-1:0]            lane_mask_i;
  logic [num_lanes*elem_width-1:0] lane_data_i;
  logic                            result_valid_o;
  logic [num_lanes*elem_width-1:0] result_o;
  logic [num_lanes-1:0]            result_mask_o;
  logic [sum_width-1:0]            result_sum_o;

  // Model state and expected results in issue order
  logic [elem_width-1:0]           model [num_lanes][num_regs];
  logic [num_lanes*elem_width-1:0] exp_data_q [$];
  logic [num_lanes-1:0]            exp_mask_q [$];
  logic [sum_width-1:0]            exp_sum_q [$];

  int    seed;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    test_errors;
  int    test_checks;
  string cur_test = "reset";

  // 100 ns period
  always #50 clk_i = ~clk_i;

  vec_unit_top vec_unit_top_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .opcode_i      (opcode_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .lane_mask_i   (lane_mask_i),
    .lane_data_i   (lane_data_i),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .result_mask_o (result_mask_o),
    .result_sum_o  (result_sum_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Bookkeeping and compares
  //////////////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  task automatic count_check(input logic bad);
    checks++;
    test_checks++;
    if (bad) begin
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_elem(input string what, input logic [elem_width-1:0] exp_v,
                            input logic [elem_width-1:0] act_v);
    count_check(act_v !== exp_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic check_sum(input string what, input logic [sum_width-1:0] exp_v,
                           input logic [sum_width-1:0] act_v);
    count_check(act_v !== exp_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic check_mask(input string what, input logic [num_lanes-1:0] exp_v,
                            input logic [num_lanes-1:0] act_v);
    count_check(act_v !== exp_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s %s: expected %b actual %b", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout in %s: %s", cur_test, what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  function automatic logic [num_lanes*elem_width-1:0] random_operands();
    random_operands = {$random(seed), $random(seed)};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue and drain
  //////////////////////////////////////////////////////////////////////

  // Drives one instruction and runs it through the model
  task automatic issue_instr(input opcode_e op, input logic [index_width-1:0] rd,
                             input logic [index_width-1:0] rs1,
                             input logic [index_width-1:0] rs2,
                             input logic [num_lanes-1:0] mask,
                             input logic [num_lanes*elem_width-1:0] data);
    logic [elem_width-1:0]           a;
    logic [elem_width-1:0]           b;
    logic [elem_width-1:0]           res;
    logic [num_lanes*elem_width-1:0] exp_d;
    logic [sum_width-1:0]            exp_s;
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    opcode_i      <= op;
    rd_i          <= rd;
    rs1_i         <= rs1;
    rs2_i         <= rs2;
    lane_mask_i   <= mask;
    lane_data_i   <= data;
    exp_d = '0;
    exp_s = '0;
    for (int k = 0; k < num_lanes; k++) begin
      a = model[k][rs1];
      b = model[k][rs2];
      case (op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_XOR:  res = a ^ b;
        OP_LDI:  res = data[k*elem_width +: elem_width];
        default: res = a;
      endcase
      // Disabled lanes neither report nor write
      if (mask[k]) begin
        exp_d[k*elem_width +: elem_width] = res;
        exp_s = exp_s + sum_width'(res);
        if (op != OP_RD) begin
          model[k][rd] = res;
        end
      end
    end
    exp_data_q.push_back(exp_d);
    exp_mask_q.push_back(mask);
    exp_sum_q.push_back(exp_s);
  endtask

  // Ends the stream and waits until every expected result was seen
  task automatic drain_results();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    while (exp_mask_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 10) begin
        abort_on_timeout("expected results still outstanding");
      end
    end
    repeat (2) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result monitor
  //////////////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : result_monitor
    logic [num_lanes*elem_width-1:0] exp_d;
    logic [num_lanes-1:0]            exp_m;
    logic [sum_width-1:0]            exp_s;
    if (rst_n_i && result_valid_o) begin
      if (exp_mask_q.size() == 0) begin
        count_check(1'b1);
        $display("Unexpected result pulse with nothing outstanding in %s", cur_test);
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_m = exp_mask_q.pop_front();
        exp_s = exp_sum_q.pop_front();
        for (int k = 0; k < num_lanes; k++) begin
          check_elem($sformatf("lane %0d", k), exp_d[k*elem_width +: elem_width],
                     result_o[k*elem_width +: elem_width]);
        end
        check_mask("mask", exp_m, result_mask_o);
        check_sum("sum", exp_s, result_sum_o);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  // Idle outputs after reset, then the first pulse 3 cycles later
  task automatic reset_and_latency();
    int   n;
    logic seen;
    begin_test("reset_and_latency");
    for (int c = 0; c < 5; c++) begin
      @(negedge clk_i);
      for (int k = 0; k < num_lanes; k++) begin
        check_elem("idle data", '0, result_o[k*elem_width +: elem_width]);
      end
      check_mask("idle mask", '0, result_mask_o);
      check_sum("idle sum", '0, result_sum_o);
    end
    issue_instr(OP_LDI, 3'd0, 3'd0, 3'd0, 4'b1111, random_operands());
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      n++;
      @(negedge clk_i);
      seen = result_valid_o;
      if (!seen && n >= 10) begin
        abort_on_timeout("no result pulse for the first instruction");
      end
    end
    count_check(n != 3);
    if (n != 3) begin
      $display("[ERROR] %s latency: expected 3 actual %0d", cur_test, n);
    end
    drain_results();
    end_test();
  endtask

  // Distinct lane operands into every register, then read them all
  task automatic load_then_read();
    logic [num_lanes*elem_width-1:0] data;
    begin_test("load_then_read");
    for (int r = 0; r < num_regs; r++) begin
      for (int k = 0; k < num_lanes; k++) begin
        data[k*elem_width +: elem_width] = 16'hc000 + elem_width'(k * 256 + r * 16 + k);
      end
      issue_instr(OP_LDI, index_width'(r), 3'd0, 3'd0, 4'b1111, data);
    end
    for (int r = 0; r < num_regs; r++) begin
      issue_instr(OP_RD, 3'd0, index_width'(r), 3'd0, 4'b1111, '0);
    end
    drain_results();
    end_test();
  endtask

  // Random ALU work, then read back every destination
  task automatic alu_random_ops();
    opcode_e op;
    begin_test("alu_random_ops");
    for (int i = 0; i < 24; i++) begin
      op = opcode_e'(3'($unsigned($random(seed)) % 4));
      issue_instr(op, index_width'($random(seed)), index_width'($random(seed)),
                  index_width'($random(seed)), 4'b1111, random_operands());
    end
    for (int r = 0; r < num_regs; r++) begin
      issue_instr(OP_RD, 3'd0, index_width'(r), 3'd0, 4'b1111, '0);
    end
    drain_results();
    end_test();
  endtask

  // Idle lanes stay out of data, mask and sum and keep their registers
  task automatic partial_mask_ops();
    begin_test("partial_mask_ops");
    for (int r = 0; r < num_regs; r++) begin
      issue_instr(OP_LDI, index_width'(r), 3'd0, 3'd0, 4'b0101, random_operands());
    end
    issue_instr(OP_ADD, 3'd2, 3'd3, 3'd4, 4'b1010, '0);
    issue_instr(OP_XOR, 3'd6, 3'd1, 3'd2, 4'b0001, '0);
    issue_instr(OP_SUB, 3'd7, 3'd5, 3'd0, 4'b1100, '0);
    for (int r = 0; r < num_regs; r++) begin
      issue_instr(OP_RD, 3'd0, index_width'(r), 3'd0, 4'b1111, '0);
    end
    drain_results();
    end_test();
  endtask

  // One instruction per cycle, every other one reads the last destination
  task automatic random_stream();
    opcode_e                op;
    logic [index_width-1:0] rd;
    logic [index_width-1:0] rs1;
    logic [index_width-1:0] prev_rd;
    logic [num_lanes-1:0]   mask;
    begin_test("random_stream");
    prev_rd = '0;
    for (int i = 0; i < 40; i++) begin
      op = opcode_e'(3'($unsigned($random(seed)) % 6));
      rd = index_width'($random(seed));
      rs1 = (i % 2 == 0) ? prev_rd : index_width'($random(seed));
      // One empty mask in the middle of the stream
      mask = (i == 20) ? 4'b0000 : num_lanes'($random(seed));
      issue_instr(op, rd, rs1, index_width'($random(seed)), mask, random_operands());
      prev_rd = rd;
    end
    drain_results();
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed = 32'hcd30;
    rst_n_i = 1'b0;
    instr_valid_i = 1'b0;
    opcode_i = OP_ADD;
    rd_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    lane_mask_i = '0;
    lane_data_i = '0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    reset_and_latency();
    load_then_read();
    alu_random_ops();
    partial_mask_ops();
    random_stream();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/vec_unit_top.sv ====
/*
  Four-lane vector register unit
  Issue stage broadcasts each instruction to all lanes, each lane
  executes against its own register file, the collector forms the
  masked results and lane sum three cycles after the input strobe
*/

`timescale 1ns/1ns

module vec_unit_top
  import vec_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Instruction in
  input  logic                            instr_valid_i,
  input  opcode_e                         opcode_i,
  input  logic [index_width-1:0]          rd_i,
  input  logic [index_width-1:0]          rs1_i,
  input  logic [index_width-1:0]          rs2_i,
  input  logic [num_lanes-1:0]            lane_mask_i,
  input  logic [num_lanes*elem_width-1:0] lane_data_i,

  // Result out
  output logic                            result_valid_o,
  output logic [num_lanes*elem_width-1:0] result_o,
  output logic [num_lanes-1:0]            result_mask_o,
  output logic [sum_width-1:0]            result_sum_o
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Issue to lanes
  logic                                 iss_valid;
  opcode_e                              iss_opcode;
  logic [index_width-1:0]               iss_rd;
  logic [index_width-1:0]               iss_rs1;
  logic [index_width-1:0]               iss_rs2;
  logic [num_lanes-1:0]                 iss_en;
  logic [num_lanes-1:0][elem_width-1:0] iss_data;

  // Lanes to collector
  logic [num_lanes-1:0]                 lane_valid;
  logic [num_lanes-1:0][elem_width-1:0] lane_result;

  // Issue strobe aligned with lane_valid
  logic                                 iss_valid_d;

  //////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////

  vec_issue vec_issue_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .opcode_i     (opcode_i),
    .rd_i         (rd_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .lane_mask_i  (lane_mask_i),
    .lane_data_i  (lane_data_i),
    .iss_valid_o  (iss_valid),
    .iss_opcode_o (iss_opcode),
    .iss_rd_o     (iss_rd),
    .iss_rs1_o    (iss_rs1),
    .iss_rs2_o    (iss_rs2),
    .iss_en_o     (iss_en),
    .iss_data_o   (iss_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < num_lanes; k++) begin : g_lanes
    vec_lane vec_lane_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (iss_valid),
      .en_i    (iss_en[k]),
      .opcode_i(iss_opcode),
      .rd_i    (iss_rd),
      .rs1_i   (iss_rs1),
      .rs2_i   (iss_rs2),
      .data_i  (iss_data[k]),
      .valid_o (lane_valid[k]),
      .result_o(lane_result[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Collector
  //////////////////////////////////////////////////////////////////////

  // Matches the lane register stage, covers an empty mask
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      iss_valid_d <= 1'b0;
    end else begin
      iss_valid_d <= iss_valid;
    end
  end

  vec_collect vec_collect_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lane_valid_i  (lane_valid),
    .lane_result_i (lane_result),
    .any_valid_i   (iss_valid_d),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .result_mask_o (result_mask_o),
    .result_sum_o  (result_sum_o)
  );

endmodule

// ==== logic/vec_collect.sv ====
/*
  Vector unit collector
  Gathers the lane results one cycle after execution, forces idle
  lanes to zero and adds the active lanes into the lane sum
  The delayed issue strobe makes an empty mask still pulse
*/

`timescale 1ns/1ns

module vec_collect
  import vec_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // From lanes
  input  logic [num_lanes-1:0]                 lane_valid_i,
  input  logic [num_lanes-1:0][elem_width-1:0] lane_result_i,
  // Delayed issue strobe
  input  logic                                 any_valid_i,

  // Unit outputs
  output logic                                 result_valid_o,
  output logic [num_lanes*elem_width-1:0]      result_o,
  output logic [num_lanes-1:0]                 result_mask_o,
  output logic [sum_width-1:0]                 result_sum_o
);

  //////////////////////////////////////////////////////////////////////
  // Masking and sum
  //////////////////////////////////////////////////////////////////////

  logic [num_lanes*elem_width-1:0] masked;
  logic [sum_width-1:0]            sum_next;

  // Idle lanes contribute zero to data and sum
  always_comb begin
    masked   = '0;
    sum_next = '0;
    for (int k = 0; k < num_lanes; k++) begin
      if (lane_valid_i[k]) begin
        masked[k*elem_width +: elem_width] = lane_result_i[k];
      end
      sum_next = sum_next + sum_width'(masked[k*elem_width +: elem_width]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  // Loaded every cycle, so everything falls back to zero between pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
      result_mask_o  <= '0;
      result_sum_o   <= '0;
    end else begin
      result_valid_o <= any_valid_i;
      result_o       <= masked;
      result_mask_o  <= lane_valid_i;
      result_sum_o   <= sum_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // No lane reports outside an instruction slot
  a_mask_in_slot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !result_valid_o |-> (result_mask_o == '0)
  );

endmodule

// ==== logic/vec_lane.sv ====
/*
  Vector unit lane
  Own register file with two read ports, reads rs1 and rs2 in the
  issue cycle, runs the ALU and writes rd back at the next edge
  Lane result and valid are registered for the collector
*/

`timescale 1ns/1ns

module vec_lane
  import vec_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Broadcast instruction
  input  logic                   valid_i,
  input  logic                   en_i,
  input  opcode_e                opcode_i,
  input  logic [index_width-1:0] rd_i,
  input  logic [index_width-1:0] rs1_i,
  input  logic [index_width-1:0] rs2_i,
  input  logic [elem_width-1:0]  data_i,

  // To collector
  output logic                   valid_o,
  output logic [elem_width-1:0]  result_o
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Port 0 reads rs1, port 1 reads rs2
  logic [index_width-1:0] rd_addr [2];
  logic [elem_width-1:0]  rd_data [2];

  logic [elem_width-1:0]  rs1_val;
  logic [elem_width-1:0]  rs2_val;
  logic [elem_width-1:0]  alu_res;
  logic                   wr_en;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  assign rd_addr[0] = rs1_i;
  assign rd_addr[1] = rs2_i;

  assign rs1_val = rd_data[0];
  assign rs2_val = rd_data[1];

  // Everything but a read writes rd
  assign wr_en = (opcode_i != OP_RD);

  // Chip select follows the lane enable
  reg_file_nr_1w #(
    .elem_width (elem_width),
    .index_width(index_width),
    .num_readers(2)
  ) reg_file_inst (
    .clk_i    (clk_i),
    .cs_i     (en_i),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data),
    .wr_addr_i(rd_i),
    .wr_data_o(),
    .wr_data_i(alu_res),
    .we_i     (wr_en)
  );

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  // Arithmetic wraps at elem_width
  always_comb begin
    case (opcode_i)
      OP_ADD:  alu_res = rs1_val + rs2_val;
      OP_SUB:  alu_res = rs1_val - rs2_val;
      OP_AND:  alu_res = rs1_val & rs2_val;
      OP_XOR:  alu_res = rs1_val ^ rs2_val;
      // Lane operand straight to rd
      OP_LDI:  alu_res = data_i;
      // Read returns rs1 unchanged
      OP_RD:   alu_res = rs1_val;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Lane result
  //////////////////////////////////////////////////////////////////////

  // Lane executed only with strobe and enable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i && en_i;
    end
  end

  // Result only meaningful while valid_o is high
  always_ff @(posedge clk_i) begin
    if (valid_i && en_i) begin
      result_o <= alu_res;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Chip select alone gates the write, so it only comes with a strobe
  a_en_with_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    en_i |-> valid_i
  );

endmodule

// ==== logic/vec_issue.sv ====
/*
  Vector unit issue stage
  Registers one instruction per cycle and broadcasts it to all lanes
  Lane enables carry the mask qualified by the input strobe
  The packed operand bus is split into one slice per lane
*/

`timescale 1ns/1ns

module vec_issue
  import vec_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // Instruction in
  input  logic                                 instr_valid_i,
  input  opcode_e                              opcode_i,
  input  logic [index_width-1:0]               rd_i,
  input  logic [index_width-1:0]               rs1_i,
  input  logic [index_width-1:0]               rs2_i,
  input  logic [num_lanes-1:0]                 lane_mask_i,
  input  logic [num_lanes*elem_width-1:0]      lane_data_i,

  // Broadcast to lanes
  output logic                                 iss_valid_o,
  output opcode_e                              iss_opcode_o,
  output logic [index_width-1:0]               iss_rd_o,
  output logic [index_width-1:0]               iss_rs1_o,
  output logic [index_width-1:0]               iss_rs2_o,
  output logic [num_lanes-1:0]                 iss_en_o,
  output logic [num_lanes-1:0][elem_width-1:0] iss_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  // Strobe and lane enables cleared by reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      iss_valid_o <= 1'b0;
      iss_en_o    <= '0;
    end else begin
      iss_valid_o <= instr_valid_i;
      // Mask only counts with a valid strobe
      iss_en_o    <= instr_valid_i ? lane_mask_i : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  // Held between instructions
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      iss_opcode_o <= opcode_i;
      iss_rd_o     <= rd_i;
      iss_rs1_o    <= rs1_i;
      iss_rs2_o    <= rs2_i;
      // Lane k takes slice k of the operand bus
      for (int k = 0; k < num_lanes; k++) begin
        iss_data_o[k] <= lane_data_i[k*elem_width +: elem_width];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Accepted instruction reaches the lanes with a legal opcode
  a_legal_opcode : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_valid_i |=> iss_opcode_o inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LDI, OP_RD}
  );

endmodule

// ==== logic/reg_file_nr_1w.sv ====
/*
  Register file with several read ports and one write port
  Reads are combinational from storage, the write lands at the
  clock edge when chip select and write enable are both high
  Storage has no reset
*/

`timescale 1ns/1ns

module reg_file_nr_1w #(
  parameter int elem_width  = 64,
  parameter int index_width = 12,
  parameter int num_readers = 2
) (
  input  logic                   clk_i,
  input  logic                   cs_i,

  // Read side
  input  logic [index_width-1:0] rd_addr_i [num_readers],
  output logic [elem_width-1:0]  rd_data_o [num_readers],

  // Write side
  input  logic [index_width-1:0] wr_addr_i,
  output logic [elem_width-1:0]  wr_data_o,
  input  logic [elem_width-1:0]  wr_data_i,
  input  logic                   we_i
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // One element per index value
  logic [elem_width-1:0] mem [2 ** index_width];

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Current contents at the write address
  assign wr_data_o = mem[wr_addr_i];

  // Each reader sees its element in the same cycle
  for (genvar i = 0; i < num_readers; i++) begin : g_readers
    assign rd_data_o[i] = mem[rd_addr_i[i]];
  end

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cs_i && we_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

// ==== logic/vec_pkg.sv ====
/*
  Vector unit shared definitions
  Lane count, element and index widths, lane sum width
  and the opcode encoding seen by the issue stage and every lane
*/

package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  // Lanes working side by side on one instruction
  localparam int num_lanes = 4;

  // One register element per lane
  localparam int elem_width = 16;

  // Register index, 8 registers per lane
  localparam int index_width = 3;
  localparam int num_regs = 2 ** index_width;

  // Two extra bits hold the carry of four lane values
  localparam int sum_width = elem_width + 2;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  // Codes 6 and 7 are illegal
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // rd = rs1 + rs2
    OP_SUB = 3'd1,  // rd = rs1 - rs2
    OP_AND = 3'd2,  // rd = rs1 & rs2
    OP_XOR = 3'd3,  // rd = rs1 ^ rs2
    OP_LDI = 3'd4,  // rd = lane operand
    OP_RD  = 3'd5   // return rs1, no write
  } opcode_e;

endpackage
